// File: source/bus_monitor_pkg.sv
// Shared types, widths, register map and reset thresholds for the I3C bus condition monitor
package bus_monitor_pkg;

  // Bus condition states, encoding is visible in STATUS[1:0]
  typedef enum logic [1:0] {
    Busy  = 2'd0,
    Free  = 2'd1,
    Avail = 2'd2,
    Idle  = 2'd3
  } bus_state_t;

  // Threshold and quiet-time counter width
  localparam int unsigned TIMER_W = 16;

  // Event counter width
  localparam int unsigned CNT_W = 16;

  // APB byte address width
  localparam int unsigned APB_AW = 5;

  // Register offsets
  localparam logic [APB_AW-1:0] REG_STATUS     = 5'h00;
  localparam logic [APB_AW-1:0] REG_T_BUF      = 5'h04;
  localparam logic [APB_AW-1:0] REG_T_AVAL     = 5'h08;
  localparam logic [APB_AW-1:0] REG_T_IDLE     = 5'h0C;
  localparam logic [APB_AW-1:0] REG_START_CNT  = 5'h10;
  localparam logic [APB_AW-1:0] REG_STOP_CNT   = 5'h14;
  // Write one to clear
  localparam logic [APB_AW-1:0] REG_IRQ_STATUS = 5'h18;
  localparam logic [APB_AW-1:0] REG_IRQ_ENABLE = 5'h1C;

  // Interrupt bit positions in IRQ_STATUS and IRQ_ENABLE
  localparam int unsigned IRQ_FREE  = 0;
  localparam int unsigned IRQ_AVAIL = 1;
  localparam int unsigned IRQ_IDLE  = 2;
  localparam int unsigned IRQ_START = 3;
  localparam int unsigned IRQ_W     = 4;

  // Threshold values after reset, in clock cycles
  localparam logic [TIMER_W-1:0] T_BUF_RST  = 16'd8;
  localparam logic [TIMER_W-1:0] T_AVAL_RST = 16'd20;
  localparam logic [TIMER_W-1:0] T_IDLE_RST = 16'd40;

endpackage

// File: source/bus_line_monitor.sv
// Synchronizes and deglitches SDA and SCL, then flags START and STOP conditions as pulses
`timescale 1ns/1ps

module bus_line_monitor #(
  // Equal samples needed before a filtered line changes
  parameter int unsigned FILTER_LEN = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic sda_i,
  input  logic scl_i,
  output logic sda_filt_o,
  output logic scl_filt_o,
  output logic start_det_o,
  output logic stop_det_o
);

  // Stability counter runs 0 .. FILTER_LEN-1
  localparam int unsigned CW = (FILTER_LEN > 1) ? $clog2(FILTER_LEN) : 1;
  localparam logic [CW-1:0] CNT_LAST = CW'(FILTER_LEN - 1);

  // Index 0 is SDA, index 1 is SCL
  localparam int unsigned LINE_SDA = 0;
  localparam int unsigned LINE_SCL = 1;

  logic [1:0]    line_raw;
  logic [1:0]    sync1_q;
  logic [1:0]    sync2_q;
  logic [1:0]    filt_q;
  logic [CW-1:0] stable_cnt_q [2];

  logic sda_prev_q;
  logic start_q;
  logic stop_q;
  logic sda_fall;
  logic sda_rise;

  assign line_raw = {scl_i, sda_i};

  // Two-flop synchronizer and glitch filter per line
  // Lines idle high, so everything resets to 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync1_q <= 2'b11;
      sync2_q <= 2'b11;
      filt_q  <= 2'b11;
      for (int i = 0; i < 2; i++) begin
        stable_cnt_q[i] <= '0;
      end
    end else begin
      sync1_q <= line_raw;
      sync2_q <= sync1_q;
      for (int i = 0; i < 2; i++) begin
        if (sync2_q[i] == filt_q[i]) begin
          // Sample agrees, drop any partial count
          stable_cnt_q[i] <= '0;
        end else if (stable_cnt_q[i] == CNT_LAST) begin
          // Held long enough, take the new level
          filt_q[i]       <= sync2_q[i];
          stable_cnt_q[i] <= '0;
        end else begin
          stable_cnt_q[i] <= stable_cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Filtered SDA edges
  assign sda_fall = sda_prev_q & ~filt_q[LINE_SDA];
  assign sda_rise = ~sda_prev_q & filt_q[LINE_SDA];

  // Previous SDA and registered condition pulses
  // START and repeated START look the same here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sda_prev_q <= 1'b1;
      start_q    <= 1'b0;
      stop_q     <= 1'b0;
    end else begin
      sda_prev_q <= filt_q[LINE_SDA];
      // SDA falls with SCL high
      start_q    <= sda_fall & filt_q[LINE_SCL];
      // SDA rises with SCL high
      stop_q     <= sda_rise & filt_q[LINE_SCL];
    end
  end

  assign sda_filt_o  = filt_q[LINE_SDA];
  assign scl_filt_o  = filt_q[LINE_SCL];
  assign start_det_o = start_q;
  assign stop_det_o  = stop_q;

endmodule

// File: source/bus_state.sv
// Bus condition FSM, tracks Busy, Free, Avail and Idle from a quiet-time counter and thresholds
`timescale 1ns/1ps

module bus_state
  import bus_monitor_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  // Filtered bus lines
  input  logic               sda_filt_i,
  input  logic               scl_filt_i,
  // Condition pulses
  input  logic               start_det_i,
  input  logic               stop_det_i,
  // Programmed thresholds in cycles
  input  logic [TIMER_W-1:0] t_buf_i,
  input  logic [TIMER_W-1:0] t_aval_i,
  input  logic [TIMER_W-1:0] t_idle_i,
  output bus_state_t         state_o,
  output logic               in_transfer_o,
  // One-cycle state entry pulses
  output logic               enter_free_o,
  output logic               enter_avail_o,
  output logic               enter_idle_o
);

  bus_state_t         state_q;
  bus_state_t         state_d;
  logic               in_transfer_q;
  logic [TIMER_W-1:0] quiet_cnt_q;
  logic               lines_high;
  logic               cnt_clear;
  logic               enter_free_q;
  logic               enter_avail_q;
  logic               enter_idle_q;

  assign lines_high = sda_filt_i & scl_filt_i;

  // Set between START and STOP
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_transfer_q <= 1'b0;
    end else if (start_det_i) begin
      in_transfer_q <= 1'b1;
    end else if (stop_det_i) begin
      in_transfer_q <= 1'b0;
    end
  end

  // Quiet time only counts after STOP with both lines high
  // Any drop of either line starts it over
  assign cnt_clear = start_det_i | stop_det_i | in_transfer_q | ~lines_high;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      quiet_cnt_q <= '0;
    end else if (cnt_clear) begin
      quiet_cnt_q <= '0;
    end else if (quiet_cnt_q != '1) begin
      // Saturates so a long idle bus stays Idle
      quiet_cnt_q <= quiet_cnt_q + 1'b1;
    end
  end

  // Next state
  // Each state only looks at the threshold of the state after it
  always_comb begin
    state_d = state_q;
    if (start_det_i) begin
      state_d = Busy;
    end else begin
      case (state_q)
        Busy: begin
          if (!in_transfer_q && (quiet_cnt_q >= t_buf_i)) begin
            state_d = Free;
          end
        end
        Free: begin
          if (quiet_cnt_q >= t_aval_i) begin
            state_d = Avail;
          end
        end
        Avail: begin
          if (quiet_cnt_q >= t_idle_i) begin
            state_d = Idle;
          end
        end
        default: begin
          state_d = state_q;
        end
      endcase
    end
  end

  // State register and entry pulses, both one cycle after the compare
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      enter_free_q  <= 1'b0;
      enter_avail_q <= 1'b0;
      enter_idle_q  <= 1'b0;
    end else begin
      state_q       <= state_d;
      enter_free_q  <= (state_d == Free) && (state_q != Free);
      enter_avail_q <= (state_d == Avail) && (state_q != Avail);
      enter_idle_q  <= (state_d == Idle) && (state_q != Idle);
    end
  end

  assign state_o       = state_q;
  assign in_transfer_o = in_transfer_q;
  assign enter_free_o  = enter_free_q;
  assign enter_avail_o = enter_avail_q;
  assign enter_idle_o  = enter_idle_q;

endmodule

// File: source/bus_monitor_regs.sv
// APB register block with thresholds, status, START and STOP counters and interrupt logic
`timescale 1ns/1ps

module bus_monitor_regs
  import bus_monitor_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  // APB slave
  input  logic [APB_AW-1:0]  paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  // Monitor status and events
  input  bus_state_t         state_i,
  input  logic               in_transfer_i,
  input  logic               start_det_i,
  input  logic               stop_det_i,
  input  logic               enter_free_i,
  input  logic               enter_avail_i,
  input  logic               enter_idle_i,
  // Thresholds to the FSM
  output logic [TIMER_W-1:0] t_buf_o,
  output logic [TIMER_W-1:0] t_aval_o,
  output logic [TIMER_W-1:0] t_idle_o,
  output logic               irq_o
);

  logic               access;
  logic               wr_en;
  logic               rd_en;
  logic               addr_hit;
  logic [31:0]        rdata;
  logic [TIMER_W-1:0] t_buf_q;
  logic [TIMER_W-1:0] t_aval_q;
  logic [TIMER_W-1:0] t_idle_q;
  logic [CNT_W-1:0]   start_cnt_q;
  logic [CNT_W-1:0]   stop_cnt_q;
  logic [IRQ_W-1:0]   irq_set;
  logic [IRQ_W-1:0]   irq_status_q;
  logic [IRQ_W-1:0]   irq_enable_q;
  logic               irq_q;

  // Access phase, zero wait states
  assign access   = psel_i & penable_i;
  assign wr_en    = access & pwrite_i;
  assign rd_en    = access & ~pwrite_i;
  assign pready_o = 1'b1;

  // Read mux, unmapped offsets read 0
  always_comb begin
    rdata    = '0;
    addr_hit = 1'b1;
    case (paddr_i)
      REG_STATUS: begin
        rdata[1:0] = state_i;
        rdata[2]   = in_transfer_i;
      end
      REG_T_BUF:      rdata[TIMER_W-1:0] = t_buf_q;
      REG_T_AVAL:     rdata[TIMER_W-1:0] = t_aval_q;
      REG_T_IDLE:     rdata[TIMER_W-1:0] = t_idle_q;
      REG_START_CNT:  rdata[CNT_W-1:0]   = start_cnt_q;
      REG_STOP_CNT:   rdata[CNT_W-1:0]   = stop_cnt_q;
      REG_IRQ_STATUS: rdata[IRQ_W-1:0]   = irq_status_q;
      REG_IRQ_ENABLE: rdata[IRQ_W-1:0]   = irq_enable_q;
      default:        addr_hit           = 1'b0;
    endcase
  end

  assign prdata_o  = rd_en ? rdata : '0;
  assign pslverr_o = access & ~addr_hit;

  // Thresholds and interrupt enables
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      t_buf_q      <= T_BUF_RST;
      t_aval_q     <= T_AVAL_RST;
      t_idle_q     <= T_IDLE_RST;
      irq_enable_q <= '0;
    end else if (wr_en) begin
      if (paddr_i == REG_T_BUF)      t_buf_q      <= pwdata_i[TIMER_W-1:0];
      if (paddr_i == REG_T_AVAL)     t_aval_q     <= pwdata_i[TIMER_W-1:0];
      if (paddr_i == REG_T_IDLE)     t_idle_q     <= pwdata_i[TIMER_W-1:0];
      if (paddr_i == REG_IRQ_ENABLE) irq_enable_q <= pwdata_i[IRQ_W-1:0];
    end
  end

  // Wrapping event counters, any write clears
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_cnt_q <= '0;
      stop_cnt_q  <= '0;
    end else begin
      if (wr_en && (paddr_i == REG_START_CNT)) start_cnt_q <= '0;
      else if (start_det_i)                    start_cnt_q <= start_cnt_q + 1'b1;
      if (wr_en && (paddr_i == REG_STOP_CNT))  stop_cnt_q  <= '0;
      else if (stop_det_i)                     stop_cnt_q  <= stop_cnt_q + 1'b1;
    end
  end

  // Event sources for the sticky status bits
  always_comb begin
    irq_set            = '0;
    irq_set[IRQ_FREE]  = enter_free_i;
    irq_set[IRQ_AVAIL] = enter_avail_i;
    irq_set[IRQ_IDLE]  = enter_idle_i;
    irq_set[IRQ_START] = start_det_i;
  end

  // New events win over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_status_q <= '0;
      irq_q        <= 1'b0;
    end else begin
      if (wr_en && (paddr_i == REG_IRQ_STATUS)) begin
        irq_status_q <= (irq_status_q & ~pwdata_i[IRQ_W-1:0]) | irq_set;
      end else begin
        irq_status_q <= irq_status_q | irq_set;
      end
      irq_q <= |(irq_status_q & irq_enable_q);
    end
  end

  assign t_buf_o  = t_buf_q;
  assign t_aval_o = t_aval_q;
  assign t_idle_o = t_idle_q;
  assign irq_o    = irq_q;

endmodule

// File: source/bus_monitor_top.sv
// Top level of the bus condition monitor, connects line filter, state FSM and APB registers
`timescale 1ns/1ps

module bus_monitor_top
  import bus_monitor_pkg::*;
#(
  parameter int unsigned FILTER_LEN = 2
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Bus lines, asynchronous to clk_i
  input  logic              sda_i,
  input  logic              scl_i,
  // APB slave
  input  logic [APB_AW-1:0] paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [31:0]       pwdata_i,
  output logic [31:0]       prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  output logic              irq_o
);

  logic               sda_filt;
  logic               scl_filt;
  logic               start_det;
  logic               stop_det;
  bus_state_t         cur_state;
  logic               in_transfer;
  logic               enter_free;
  logic               enter_avail;
  logic               enter_idle;
  logic [TIMER_W-1:0] t_buf;
  logic [TIMER_W-1:0] t_aval;
  logic [TIMER_W-1:0] t_idle;

  // Line filter and START/STOP detection
  bus_line_monitor #(
    .FILTER_LEN(FILTER_LEN)
  ) u_line_monitor (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .sda_i      (sda_i),
    .scl_i      (scl_i),
    .sda_filt_o (sda_filt),
    .scl_filt_o (scl_filt),
    .start_det_o(start_det),
    .stop_det_o (stop_det)
  );

  // Bus condition FSM
  bus_state u_bus_state (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sda_filt_i   (sda_filt),
    .scl_filt_i   (scl_filt),
    .start_det_i  (start_det),
    .stop_det_i   (stop_det),
    .t_buf_i      (t_buf),
    .t_aval_i     (t_aval),
    .t_idle_i     (t_idle),
    .state_o      (cur_state),
    .in_transfer_o(in_transfer),
    .enter_free_o (enter_free),
    .enter_avail_o(enter_avail),
    .enter_idle_o (enter_idle)
  );

  // Register block
  bus_monitor_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .state_i      (cur_state),
    .in_transfer_i(in_transfer),
    .start_det_i  (start_det),
    .stop_det_i   (stop_det),
    .enter_free_i (enter_free),
    .enter_avail_i(enter_avail),
    .enter_idle_i (enter_idle),
    .t_buf_o      (t_buf),
    .t_aval_o     (t_aval),
    .t_idle_o     (t_idle),
    .irq_o        (irq_o)
  );

endmodule

// File: testbench/tb_bus_monitor.sv
// Testbench for the bus condition monitor, drives SDA/SCL frames and checks it over APB
`timescale 1ns/1ps

module tb_bus_monitor
  import bus_monitor_pkg::*;
();

  localparam int FILTER_LEN = 2;
  // Line edge to state change, synchronizer plus filter plus pulse and FSM registers
  localparam int STATE_LAT = FILTER_LEN + 5;
  // Distance kept from every threshold when sampling STATUS
  localparam int MARGIN = 10;
  // About four times the whole test sequence
  localparam int TIMEOUT_CYCLES = 20000;

  logic              clk;
  logic              rst_n;
  logic              sda;
  logic              scl;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic              irq;

  int          cycle_cnt = 0;
  int          errors;
  int          checks;
  int          status_errors = 0;
  int          status_checks = 0;
  int          cmp_idx = 0;
  int          irq_high_cnt = 0;
  bit          irq_watch;
  // Bus model
  bit          started;
  bit          stopped;
  int          stop_cycle;
  int          tb_starts;
  int          tb_stops;
  int          cur_tb;
  int          cur_ta;
  int          cur_ti;
  logic [31:0] rng_state = 32'd67;
  // STATUS samples, expected and read
  logic [2:0]  exp_q[$];
  logic [2:0]  got_q[$];

  bus_monitor_top #(
    .FILTER_LEN(FILTER_LEN)
  ) DUT (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .sda_i    (sda),
    .scl_i    (scl),
    .paddr_i  (paddr),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .pwdata_i (pwdata),
    .prdata_o (prdata),
    .pready_o (pready),
    .pslverr_o(pslverr),
    .irq_o    (irq)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Cycle count, also the run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Counts cycles with irq_o high while watched
  always @(negedge clk) begin
    if (irq_watch && irq) irq_high_cnt <= irq_high_cnt + 1;
  end

  // Compares every STATUS read against the model
  always @(negedge clk) begin
    while (cmp_idx < got_q.size()) begin
      status_checks = status_checks + 1;
      if (got_q[cmp_idx] !== exp_q[cmp_idx]) begin
        status_errors = status_errors + 1;
        $display("FAIL STATUS exp=0x%0h got=0x%0h (sample %0d)",
                 exp_q[cmp_idx], got_q[cmp_idx], cmp_idx);
      end
      cmp_idx = cmp_idx + 1;
    end
  end

  // Threshold rule, quiet is counted from the STOP edge on the lines
  function automatic bus_state_t expected_state(input bit seen_start, input int quiet,
                                                input int t_buf, input int t_aval,
                                                input int t_idle);
    int q;
    q = quiet - STATE_LAT;
    if (seen_start) return Busy;
    if (q >= t_idle) return Idle;
    if (q >= t_aval) return Avail;
    if (q >= t_buf) return Free;
    return Busy;
  endfunction

  function automatic int next_random(input int range);
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return int'(rng_state[30:16]) % range;
  endfunction

  task automatic hold_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwdata  <= data;
    pwrite  <= 1'b1;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err, output int at_cycle);
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    // Access cycle, data is stable here
    @(negedge clk);
    data     = prdata;
    err      = pslverr;
    at_cycle = cycle_cnt;
    if (pready !== 1'b1) begin
      errors = errors + 1;
      $display("pready was low during an access cycle");
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    if (err !== 1'b0) begin
      errors = errors + 1;
      $display("Unexpected pslverr on write to offset 0x%0h", addr);
    end
  endtask

  task automatic read_reg(input logic [APB_AW-1:0] addr, input string name,
                          input logic [31:0] exp);
    logic [31:0] d;
    logic        err;
    int          c;
    apb_read(addr, d, err, c);
    checks = checks + 1;
    if (d !== exp) begin
      errors = errors + 1;
      $display("FAIL %s exp=0x%08h got=0x%08h", name, exp, d);
    end
    if (err !== 1'b0) begin
      errors = errors + 1;
      $display("Unexpected pslverr on read of %s", name);
    end
  endtask

  // Reads STATUS and queues it with the model value
  task automatic check_status();
    logic [31:0] d;
    logic        err;
    int          c;
    int          quiet;
    bus_state_t  st;
    apb_read(REG_STATUS, d, err, c);
    // No STOP yet means the bus has been quiet since reset
    quiet = stopped ? (c - stop_cycle) : 32'h0010_0000;
    st    = expected_state(started, quiet, cur_tb, cur_ta, cur_ti);
    exp_q.push_back({started, st});
    got_q.push_back(d[2:0]);
  endtask

  task automatic check_irq(input logic exp);
    @(negedge clk);
    checks = checks + 1;
    if (irq !== exp) begin
      errors = errors + 1;
      $display("FAIL irq_o exp=0x%0h got=0x%0h", exp, irq);
    end
  endtask

  task automatic drive_lines(input logic s, input logic c, input int n);
    @(posedge clk);
    sda <= s;
    scl <= c;
    hold_cycles(n - 1);
  endtask

  // SDA falls with SCL high, then SCL low
  task automatic bus_start();
    drive_lines(1'b0, 1'b1, 6);
    started   = 1'b1;
    tb_starts = tb_starts + 1;
    drive_lines(1'b0, 1'b0, 6);
  endtask

  // MSB first, SDA only moves while SCL is low
  task automatic send_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      drive_lines(b[i], 1'b0, 3);
      drive_lines(b[i], 1'b1, 6);
      drive_lines(b[i], 1'b0, 3);
    end
  endtask

  task automatic bus_rstart();
    drive_lines(1'b1, 1'b0, 6);
    drive_lines(1'b1, 1'b1, 6);
    drive_lines(1'b0, 1'b1, 6);
    tb_starts = tb_starts + 1;
    drive_lines(1'b0, 1'b0, 6);
  endtask

  // SDA rises with SCL high, quiet time is measured from this edge
  task automatic bus_stop();
    drive_lines(1'b0, 1'b0, 6);
    drive_lines(1'b0, 1'b1, 6);
    @(posedge clk);
    sda <= 1'b1;
    @(negedge clk);
    stop_cycle = cycle_cnt;
    stopped    = 1'b1;
    started    = 1'b0;
    tb_stops   = tb_stops + 1;
  endtask

  // Leaves two cycles for the read setup
  task automatic wait_quiet(input int n);
    while (cycle_cnt - stop_cycle < n - 2) @(negedge clk);
  endtask

  // Samples STATUS on both sides of each threshold
  task automatic quiet_walk();
    int th[3];
    int last;
    int pt;
    th[0] = cur_tb;
    th[1] = cur_ta;
    th[2] = cur_ti;
    last  = 0;
    for (int i = 0; i < 3; i++) begin
      for (int k = 0; k < 2; k++) begin
        pt = th[i] + ((k == 0) ? -MARGIN : MARGIN) + STATE_LAT;
        // Skip points that overlap the previous read
        if (pt >= 12 && pt >= last + 4) begin
          wait_quiet(pt);
          check_status();
          last = pt;
        end
      end
    end
  endtask

  task automatic set_thresholds(input int b, input int a, input int i);
    write_reg(REG_T_BUF, 32'(b));
    write_reg(REG_T_AVAL, 32'(a));
    write_reg(REG_T_IDLE, 32'(i));
    cur_tb = b;
    cur_ta = a;
    cur_ti = i;
  endtask

  task automatic run_frame(input bit with_rstart);
    bus_start();
    send_byte(8'(next_random(256)));
    if (with_rstart) begin
      bus_rstart();
      send_byte(8'(next_random(256)));
    end
    bus_stop();
    hold_cycles(20 + next_random(60));
  endtask

  // Low pulse on SDA, too short for the filter
  task automatic glitch_sda(input int w);
    @(posedge clk);
    sda <= 1'b0;
    repeat (w) @(posedge clk);
    sda <= 1'b1;
  endtask

  // Full frame and wait until the FSM is back in Idle
  task automatic frame_to_idle();
    bus_start();
    send_byte(8'h3C);
    bus_stop();
    wait_quiet(cur_ti + STATE_LAT + MARGIN);
  endtask

  initial begin
    logic [31:0] d;
    logic        err;
    int          c;
    int          irq_before;
    logic [APB_AW-1:0] bad_addr[3];
    logic [31:0] timer_mask;

    sda       = 1'b1;
    scl       = 1'b1;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    rst_n     = 1'b0;
    errors    = 0;
    checks    = 0;
    irq_watch = 1'b0;
    started   = 1'b0;
    stopped   = 1'b0;
    tb_starts = 0;
    tb_stops  = 0;
    cur_tb    = int'(T_BUF_RST);
    cur_ta    = int'(T_AVAL_RST);
    cur_ti    = int'(T_IDLE_RST);
    timer_mask  = (32'd1 << TIMER_W) - 32'd1;
    bad_addr[0] = 5'h02;
    bad_addr[1] = 5'h0D;
    bad_addr[2] = 5'h1F;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    hold_cycles(2);

    // Reset values and threshold read back
    check_status();
    read_reg(REG_T_BUF, "T_BUF", 32'(T_BUF_RST));
    read_reg(REG_T_AVAL, "T_AVAL", 32'(T_AVAL_RST));
    read_reg(REG_T_IDLE, "T_IDLE", 32'(T_IDLE_RST));
    read_reg(REG_START_CNT, "START_CNT", 32'h0);
    read_reg(REG_STOP_CNT, "STOP_CNT", 32'h0);
    read_reg(REG_IRQ_STATUS, "IRQ_STATUS", 32'h0);
    read_reg(REG_IRQ_ENABLE, "IRQ_ENABLE", 32'h0);
    write_reg(REG_T_BUF, 32'hABCD_0123);
    read_reg(REG_T_BUF, "T_BUF", 32'hABCD_0123 & timer_mask);
    write_reg(REG_T_AVAL, 32'h5A5A_0456);
    read_reg(REG_T_AVAL, "T_AVAL", 32'h5A5A_0456 & timer_mask);
    write_reg(REG_T_IDLE, 32'h0001_0789);
    read_reg(REG_T_IDLE, "T_IDLE", 32'h0001_0789 & timer_mask);
    set_thresholds(int'(T_BUF_RST), int'(T_AVAL_RST), int'(T_IDLE_RST));

    // State walk with reset thresholds, then random ones
    bus_start();
    check_status();
    send_byte(8'hA5);
    bus_stop();
    quiet_walk();
    for (int r = 0; r < 3; r++) begin
      c = 10 + next_random(30);
      set_thresholds(c, c + 15 + next_random(30), c + 45 + next_random(40));
      bus_start();
      check_status();
      send_byte(8'(next_random(256)));
      bus_stop();
      quiet_walk();
    end

    // Event counters over random frames, some with repeated START
    write_reg(REG_START_CNT, 32'h0);
    write_reg(REG_STOP_CNT, 32'h0);
    tb_starts = 0;
    tb_stops  = 0;
    for (int f = 0; f < 6; f++) begin
      run_frame(next_random(2) == 1);
    end
    read_reg(REG_START_CNT, "START_CNT", 32'(tb_starts));
    read_reg(REG_STOP_CNT, "STOP_CNT", 32'(tb_stops));
    write_reg(REG_START_CNT, 32'hFFFF_FFFF);
    write_reg(REG_STOP_CNT, 32'h1);
    tb_starts = 0;
    tb_stops  = 0;
    read_reg(REG_START_CNT, "START_CNT", 32'h0);
    read_reg(REG_STOP_CNT, "STOP_CNT", 32'h0);

    // Short SDA glitches on an idle bus
    wait_quiet(cur_ti + STATE_LAT + MARGIN);
    for (int g = 0; g < 5; g++) begin
      glitch_sda(1 + next_random(FILTER_LEN - 1));
      hold_cycles(5 + next_random(10));
    end
    hold_cycles(10);
    check_status();
    read_reg(REG_START_CNT, "START_CNT", 32'(tb_starts));
    read_reg(REG_STOP_CNT, "STOP_CNT", 32'(tb_stops));

    // Interrupts enabled
    write_reg(REG_IRQ_ENABLE, 32'hF);
    write_reg(REG_IRQ_STATUS, 32'hF);
    hold_cycles(3);
    check_irq(1'b0);
    read_reg(REG_IRQ_STATUS, "IRQ_STATUS", 32'h0);
    bus_start();
    check_irq(1'b1);
    read_reg(REG_IRQ_STATUS, "IRQ_STATUS", 32'(1 << IRQ_START));
    write_reg(REG_IRQ_STATUS, 32'(1 << IRQ_START));
    hold_cycles(3);
    check_irq(1'b0);
    send_byte(8'h96);
    bus_stop();
    wait_quiet(cur_ti + STATE_LAT + MARGIN);
    check_status();
    check_irq(1'b1);
    read_reg(REG_IRQ_STATUS, "IRQ_STATUS",
             32'((1 << IRQ_FREE) | (1 << IRQ_AVAIL) | (1 << IRQ_IDLE)));
    write_reg(REG_IRQ_STATUS, 32'h7);
    hold_cycles(3);
    check_irq(1'b0);
    read_reg(REG_IRQ_STATUS, "IRQ_STATUS", 32'h0);

    // Interrupts masked, status still latches
    write_reg(REG_IRQ_ENABLE, 32'h0);
    hold_cycles(2);
    irq_before = irq_high_cnt;
    irq_watch  = 1'b1;
    frame_to_idle();
    irq_watch  = 1'b0;
    hold_cycles(1);
    checks = checks + 1;
    if (irq_high_cnt != irq_before) begin
      errors = errors + 1;
      $display("irq_o went high while all enables were 0");
    end
    read_reg(REG_IRQ_STATUS, "IRQ_STATUS", 32'hF);

    // Unmapped offsets
    for (int a = 0; a < 3; a++) begin
      apb_write(bad_addr[a], 32'hFFFF_FFFF, err);
      checks = checks + 1;
      if (err !== 1'b1) begin
        errors = errors + 1;
        $display("No pslverr on write to unmapped offset 0x%0h", bad_addr[a]);
      end
      apb_read(bad_addr[a], d, err, c);
      if (err !== 1'b1) begin
        errors = errors + 1;
        $display("No pslverr on read of unmapped offset 0x%0h", bad_addr[a]);
      end
      if (d !== 32'h0) begin
        errors = errors + 1;
        $display("FAIL prdata exp=0x%08h got=0x%08h", 32'h0, d);
      end
    end
    read_reg(REG_T_BUF, "T_BUF", 32'(cur_tb));
    read_reg(REG_T_AVAL, "T_AVAL", 32'(cur_ta));
    read_reg(REG_T_IDLE, "T_IDLE", 32'(cur_ti));
    read_reg(REG_START_CNT, "START_CNT", 32'(tb_starts));
    read_reg(REG_STOP_CNT, "STOP_CNT", 32'(tb_stops));
    read_reg(REG_IRQ_STATUS, "IRQ_STATUS", 32'hF);
    read_reg(REG_IRQ_ENABLE, "IRQ_ENABLE", 32'h0);
    check_status();

    // Let the compare process drain
    hold_cycles(4);
    $display("Errors: %0d of %0d checks", errors + status_errors, checks + status_checks);
    if (errors + status_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
source/bus_monitor_pkg.sv
source/bus_line_monitor.sv
source/bus_state.sv
source/bus_monitor_regs.sv
source/bus_monitor_top.sv
testbench/tb_bus_monitor.sv

// File: run_sim.sh
#!/bin/sh
# Builds the bus monitor testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f flist.f --top-module tb_bus_monitor \
    -o tb_bus_monitor; then
  echo "Compile failed"
  exit 1
fi

if ! out=$(./obj_dir/tb_bus_monitor); then
  echo "$out"
  echo "Simulation exited with an error"
  exit 1
fi
echo "$out"

if echo "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
